// ==== Bender.yml ====
package:
  name: rv64_core

sources:
  - design/core_pkg.sv
  - design/reg_file.sv
  - design/instr_fetch.sv
  - design/instr_decode.sv
  - design/execute_unit.sv
  - design/mem_stage.sv
  - design/mem_arbiter.sv
  - design/core_top.sv
  - target: simulation
    files:
      - bench/mem_model.sv
      - bench/core_tb.sv

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*; ();

  localparam int    CLK_PERIOD    = 8;
  localparam int    N_ENTRIES     = 17;
  localparam int    SETTLE_CYCLES = 40;        // Quiet window after the expected store
  localparam int    WATCHDOG_CYC  = N_ENTRIES * 400;
  localparam addr_t ENTRY         = 64'h100;
  localparam addr_t RESULT_ADDR   = 64'h400;   // Held in x10
  localparam addr_t OPA_ADDR      = 64'h500;   // x10 + 0x100
  localparam addr_t OPB_ADDR      = 64'h508;
  localparam addr_t DATA_ADDR     = 64'h510;
  localparam addr_t JAL_PC        = ENTRY + 64'd12; // After the three setup instructions
  localparam xlen_t MARK_FALL     = 64'h111;
  localparam xlen_t MARK_TAKEN    = 64'h222;

  // RV64 encodings
  localparam logic [6:0] RV_OP_IMM = 7'b0010011;
  localparam logic [6:0] RV_OP     = 7'b0110011;
  localparam logic [6:0] RV_LUI    = 7'b0110111;
  localparam logic [6:0] RV_LOAD   = 7'b0000011;

  typedef enum {
    KIND_ADDI, KIND_ADD, KIND_SUB, KIND_AND, KIND_OR, KIND_XOR,
    KIND_LUI, KIND_LD, KIND_BEQ, KIND_BNE, KIND_JAL
  } op_kind_e;

  logic  clk, reset;
  addr_t entry;
  logic  mem_req, mem_we, mem_ack;
  addr_t mem_addr;
  xlen_t mem_wdata, mem_rdata;
  logic  preload_en;
  addr_t preload_addr;
  xlen_t preload_data;
  logic  wr_valid;
  addr_t wr_addr;
  xlen_t wr_data;

  op_kind_e    kind_tab [N_ENTRIES];
  xlen_t       a_tab    [N_ENTRIES];
  xlen_t       b_tab    [N_ENTRIES]; // Low 12 bits act as immediate
  xlen_t       data_tab [N_ENTRIES];
  xlen_t       exp_tab  [N_ENTRIES];
  int          n_loaded = 0;
  instr_t      prog [$];
  int          store_count = 0;
  xlen_t       store_data;

  core_top uut (
    .clk, .reset, .entry, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
  );

  mem_model memory (
    .clk, .reset, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata,
    .preload_en, .preload_addr, .preload_data, .wr_valid, .wr_addr, .wr_data
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input xlen_t expected, input xlen_t actual);
    if (actual !== expected)
      abort_run($sformatf("Error: %s expected %h, got %h", name, expected, actual));
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected)
      abort_run($sformatf("Error: %s expected %h, got %h", name, expected, actual));
  endtask

  // Architectural result of each test program
  function automatic xlen_t expected_result(input op_kind_e k, input xlen_t a, input xlen_t b,
                                            input xlen_t d);
    xlen_t imm;
    imm = {{52{b[11]}}, b[11:0]};
    case (k)
      KIND_ADDI: return a + imm;
      KIND_ADD:  return a + b;
      KIND_SUB:  return a - b;
      KIND_AND:  return a & b;
      KIND_OR:   return a | b;
      KIND_XOR:  return a ^ b;
      KIND_LUI:  return {{32{a[19]}}, a[19:0], 12'h000} + imm; // U type sign extends bit 31
      KIND_LD:   return d + imm;
      KIND_BEQ:  return (a == b) ? MARK_TAKEN : MARK_FALL;
      KIND_BNE:  return (a != b) ? MARK_TAKEN : MARK_FALL;
      default:   return JAL_PC + 64'd4; // Link address
    endcase
  endfunction

  task automatic add_entry(input op_kind_e k, input xlen_t a, input xlen_t b, input xlen_t d);
    kind_tab[n_loaded] = k;
    a_tab[n_loaded]    = a;
    b_tab[n_loaded]    = b;
    data_tab[n_loaded] = d;
    exp_tab[n_loaded]  = expected_result(k, a, b, d);
    n_loaded++;
  endtask

  task automatic load_table();
    add_entry(KIND_ADDI, 64'h7FFF_FFFF_FFFF_FFFF, 64'h001, 64'h0); // Wraps to sign bit
    add_entry(KIND_ADDI, 64'h5, 64'hFFD, 64'h0);                   // Negative immediate
    add_entry(KIND_ADD,  64'hFFFF_FFFF_FFFF_FFFF, 64'h2, 64'h0);
    add_entry(KIND_ADD,  64'h0123_4567_89AB_CDEF, 64'h1111_1111_1111_1111, 64'h0);
    add_entry(KIND_SUB,  64'h3, 64'h5, 64'h0);
    add_entry(KIND_AND,  64'hF0F0_F0F0_FFFF_0000, 64'h0FF0_0FF0_1234_5678, 64'h0);
    add_entry(KIND_OR,   64'hF0F0_0000_0000_000F, 64'h0000_0F0F_A5A5_0000, 64'h0);
    add_entry(KIND_XOR,  64'hAAAA_AAAA_AAAA_AAAA, 64'hFFFF_0000_FFFF_0000, 64'h0);
    add_entry(KIND_LUI,  64'h80000, 64'h7FF, 64'h0);
    add_entry(KIND_LUI,  64'h12345, 64'h800, 64'h0);
    add_entry(KIND_LD,   64'h0, 64'h010, 64'h0123_4567_89AB_CDEF);
    add_entry(KIND_LD,   64'h0, 64'h001, 64'hFFFF_FFFF_FFFF_FFFF);
    add_entry(KIND_BEQ,  64'h55, 64'h55, 64'h0);
    add_entry(KIND_BEQ,  64'h1, 64'h2, 64'h0);
    add_entry(KIND_BNE,  64'h1, 64'h2, 64'h0);
    add_entry(KIND_BNE,  64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 64'h0);
    add_entry(KIND_JAL,  64'h0, 64'h0, 64'h0);
  endtask

  function automatic instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, RV_OP}; // x3 = x1 op x2
  endfunction

  function automatic instr_t enc_sd(input logic [4:0] rs2); // SD rs2, 0(x10)
    return {7'b0, rs2, 5'd10, 3'b011, 5'b0, 7'b0100011};
  endfunction

  function automatic instr_t enc_b(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic instr_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic build_program(input int n);
    op_kind_e    k;
    logic [11:0] imm;
    k   = kind_tab[n];
    imm = b_tab[n][11:0];
    prog.delete();
    prog.push_back(enc_i(12'h400, 5'd0, 3'b000, 5'd10, RV_OP_IMM)); // x10 = result address
    prog.push_back(enc_i(12'h100, 5'd10, 3'b011, 5'd1, RV_LOAD));   // x1 = A
    prog.push_back(enc_i(12'h108, 5'd10, 3'b011, 5'd2, RV_LOAD));   // x2 = B
    case (k)
      KIND_ADDI: prog.push_back(enc_i(imm, 5'd1, 3'b000, 5'd3, RV_OP_IMM));
      KIND_ADD:  prog.push_back(enc_r(7'h00, 3'b000));
      KIND_SUB:  prog.push_back(enc_r(7'h20, 3'b000));
      KIND_AND:  prog.push_back(enc_r(7'h00, 3'b111));
      KIND_OR:   prog.push_back(enc_r(7'h00, 3'b110));
      KIND_XOR:  prog.push_back(enc_r(7'h00, 3'b100));
      KIND_LUI: begin
        prog.push_back({a_tab[n][19:0], 5'd3, RV_LUI});
        prog.push_back(enc_i(imm, 5'd3, 3'b000, 5'd3, RV_OP_IMM));
      end
      KIND_LD: begin
        prog.push_back(enc_i(12'h110, 5'd10, 3'b011, 5'd4, RV_LOAD));
        prog.push_back(enc_i(imm, 5'd4, 3'b000, 5'd3, RV_OP_IMM));
      end
      KIND_BEQ, KIND_BNE: begin
        prog.push_back(enc_b(13'd16, (k == KIND_BNE) ? 3'b001 : 3'b000)); // To taken path
        prog.push_back(enc_i(MARK_FALL[11:0], 5'd0, 3'b000, 5'd3, RV_OP_IMM));
        prog.push_back(enc_sd(5'd3));
        prog.push_back(enc_j(21'd0, 5'd0));
        prog.push_back(enc_i(MARK_TAKEN[11:0], 5'd0, 3'b000, 5'd3, RV_OP_IMM));
      end
      default: begin
        prog.push_back(enc_j(21'd8, 5'd5));                       // Sits at JAL_PC
        prog.push_back(enc_i(12'h0, 5'd0, 3'b000, 5'd5, RV_OP_IMM)); // Skipped
      end
    endcase
    prog.push_back(enc_sd((k == KIND_JAL) ? 5'd5 : 5'd3));
    prog.push_back(enc_j(21'd0, 5'd0)); // Park in a tight loop
  endtask

  task automatic write_memory(input addr_t a, input xlen_t d);
    preload_en   = 1'b1;
    preload_addr = a;
    preload_data = d;
    @(negedge clk);
    preload_en   = 1'b0;
  endtask

  task automatic run_entry(input int n);
    xlen_t dword;
    build_program(n);
    reset = 1'b1;
    for (int i = 0; i < prog.size(); i += 2) begin
      dword[31:0]  = prog[i];                                    // Even slot is the low half
      dword[63:32] = (i + 1 < prog.size()) ? prog[i + 1] : 32'h0;
      write_memory(ENTRY + addr_t'(4 * i), dword);
    end
    write_memory(OPA_ADDR, a_tab[n]);
    write_memory(OPB_ADDR, b_tab[n]);
    write_memory(DATA_ADDR, data_tab[n]);
    repeat (2) begin
      @(negedge clk);
      if (mem_req) abort_run("mem_req rose while reset was held");
    end
    store_count = 0;
    reset       = 1'b0;
    while (!mem_req) @(negedge clk);
    check_addr("mem_addr", ENTRY, mem_addr);
    while (store_count == 0) @(negedge clk);
    check_data("wr_data", exp_tab[n], store_data);
    repeat (SETTLE_CYCLES) @(negedge clk);
    if (store_count != 1) abort_run("a second store reached the result address");
  endtask

  // Every bus write must target the result address
  always @(posedge clk) begin
    if (wr_valid) begin
      check_addr("wr_addr", RESULT_ADDR, wr_addr);
      store_data  = wr_data;
      store_count = store_count + 1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    abort_run("the store to the result address never arrived before the watchdog expired");
  end

  initial begin
    reset        = 1'b1;
    entry        = ENTRY;
    preload_en   = 1'b0;
    preload_addr = '0;
    preload_data = '0;
    load_table();
    @(negedge clk);
    for (int n = 0; n < N_ENTRIES; n++) run_entry(n);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model import core_pkg::*; (
  input  wire   clk,
  input  wire   reset,
  input  wire   mem_req,
  input  wire   mem_we,
  input  addr_t mem_addr,
  input  xlen_t mem_wdata,
  output logic  mem_ack,
  output xlen_t mem_rdata,
  input  wire   preload_en,   // Bench side write port that works during reset
  input  addr_t preload_addr,
  input  xlen_t preload_data,
  output logic  wr_valid,     // One cycle pulse per bus write
  output addr_t wr_addr,
  output xlen_t wr_data
);

  localparam int unsigned SEED = 90;

  xlen_t      words [256];  // 2 KB of doublewords
  logic       busy;         // Handshake in progress
  logic [1:0] delay;        // Cycles left before ack
  logic [7:0] idx;

  assign idx = mem_addr[10:3];

  // Empty memory decodes as no-ops
  initial begin
    for (int i = 0; i < 256; i++) words[i] = '0;
  end

  initial begin
    void'($urandom(SEED)); // Seeds the ack delay draws
    forever begin
      @(posedge clk);
      wr_valid <= 1'b0;
      if (preload_en) words[preload_addr[10:3]] <= preload_data;
      if (reset) begin
        mem_ack   <= 1'b0;
        mem_rdata <= '0;
        busy      <= 1'b0;
        delay     <= '0;
      end else if (!busy) begin
        if (mem_req) begin
          busy  <= 1'b1;
          delay <= 2'($urandom_range(3, 0)); // Random ack latency
        end
      end else if (!mem_ack) begin
        if (delay != 2'd0) begin
          delay <= delay - 2'd1;
        end else begin
          mem_ack   <= 1'b1;
          mem_rdata <= words[idx];
          if (mem_we) begin
            words[idx] <= mem_wdata;
            wr_valid   <= 1'b1;
            wr_addr    <= mem_addr;
            wr_data    <= mem_wdata;
          end
        end
      end else if (!mem_req) begin
        mem_ack <= 1'b0; // Phase 4 closes the handshake
        busy    <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/core_pkg.sv ====
`default_nettype none

package core_pkg;

  typedef logic [63:0] xlen_t;    // Data word
  typedef logic [63:0] addr_t;    // Byte address
  typedef logic [31:0] instr_t;   // Instruction word
  typedef logic [4:0]  reg_idx_t; // Register number
  typedef logic [6:0]  opcode_t;  // Major opcode

  // RV64 major opcodes
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;

  localparam logic [2:0] FUNCT3_DOUBLE = 3'b011; // LD / SD width
  localparam addr_t      INSTR_BYTES   = 64'd4;  // PC step

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS // Immediate straight through for LUI
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_LINK,
    WB_NONE
  } wb_sel_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_REL
  } fetch_state_e;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_REQ,
    MEM_REL,
    MEM_RETIRE
  } mem_state_e;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_FETCH,
    OWN_DATA
  } arb_owner_e;

endpackage

`default_nettype wire

// ==== design/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
  input  wire   clk,
  input  wire   reset,
  input  addr_t entry,
  output logic  mem_req,
  output logic  mem_we,
  output addr_t mem_addr,
  output xlen_t mem_wdata,
  input  wire   mem_ack,
  input  xlen_t mem_rdata
);

  logic     fb_valid, fb_take;
  instr_t   fb_instr;
  addr_t    fb_pc;
  logic     f_req, f_ack;
  addr_t    f_addr;
  xlen_t    f_rdata;
  logic     d_req, d_we, d_ack;
  addr_t    d_addr;
  xlen_t    d_wdata, d_rdata;
  reg_idx_t rs1, rs2, ex_rd, mem_rd, wb_rd;
  xlen_t    rs1_data, rs2_data;
  logic     ex_valid, ex_is_load, ex_is_store, ex_is_branch, ex_branch_ne, ex_is_jal;
  alu_op_e  ex_alu_op;
  wb_sel_e  ex_wb_sel, mem_wb_sel;
  xlen_t    ex_a, ex_b, ex_imm;
  addr_t    ex_pc, redirect_pc;
  logic     redirect, mem_valid, mem_is_load, mem_is_store;
  xlen_t    mem_result, mem_store_data, wb_data;
  logic     wb_en, retire;

  instr_fetch u_fetch (
    .clk, .reset, .entry, .redirect, .redirect_pc, .fb_take, .fb_valid, .fb_instr, .fb_pc,
    .f_req, .f_addr, .f_ack, .f_rdata
  );

  instr_decode u_decode (
    .clk, .reset, .fb_valid, .fb_instr, .fb_pc, .fb_take, .rs1, .rs2, .rs1_data, .rs2_data,
    .retire, .ex_valid, .ex_alu_op, .ex_wb_sel, .ex_rd, .ex_a, .ex_b, .ex_imm, .ex_pc,
    .ex_is_load, .ex_is_store, .ex_is_branch, .ex_branch_ne, .ex_is_jal
  );

  reg_file u_regs (
    .clk, .reset, .rs1, .rs2, .rs1_data, .rs2_data, .wb_en, .wb_rd, .wb_data
  );

  execute_unit u_execute (
    .clk, .reset, .ex_valid, .ex_alu_op, .ex_wb_sel, .ex_rd, .ex_a, .ex_b, .ex_imm, .ex_pc,
    .ex_is_load, .ex_is_store, .ex_is_branch, .ex_branch_ne, .ex_is_jal,
    .redirect, .redirect_pc, .mem_valid, .mem_result, .mem_store_data, .mem_rd,
    .mem_wb_sel, .mem_is_load, .mem_is_store
  );

  mem_stage u_mem (
    .clk, .reset, .mem_valid, .mem_result, .mem_store_data, .mem_rd, .mem_wb_sel,
    .mem_is_load, .mem_is_store, .d_req, .d_we, .d_addr, .d_wdata, .d_ack, .d_rdata,
    .wb_en, .wb_rd, .wb_data, .retire
  );

  // Fetch and data share the one external bus
  mem_arbiter u_arb (
    .clk, .reset, .f_req, .f_addr, .f_ack, .f_rdata,
    .d_req, .d_we, .d_addr, .d_wdata, .d_ack, .d_rdata,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
  );

endmodule

`default_nettype wire

// ==== design/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit import core_pkg::*; (
  input  wire      clk,
  input  wire      reset,
  input  wire      ex_valid,
  input  alu_op_e  ex_alu_op,
  input  wb_sel_e  ex_wb_sel,
  input  reg_idx_t ex_rd,
  input  xlen_t    ex_a,
  input  xlen_t    ex_b,
  input  xlen_t    ex_imm,
  input  addr_t    ex_pc,
  input  wire      ex_is_load,
  input  wire      ex_is_store,
  input  wire      ex_is_branch,
  input  wire      ex_branch_ne,
  input  wire      ex_is_jal,
  output logic     redirect,
  output addr_t    redirect_pc,
  output logic     mem_valid,
  output xlen_t    mem_result,
  output xlen_t    mem_store_data,
  output reg_idx_t mem_rd,
  output wb_sel_e  mem_wb_sel,
  output logic     mem_is_load,
  output logic     mem_is_store
);

  xlen_t alu_out;
  addr_t mem_addr;
  addr_t link;
  logic  taken;

  always_comb begin
    case (ex_alu_op)
      ALU_SUB:  alu_out = ex_a - ex_b;
      ALU_AND:  alu_out = ex_a & ex_b;
      ALU_OR:   alu_out = ex_a | ex_b;
      ALU_XOR:  alu_out = ex_a ^ ex_b;
      ALU_PASS: alu_out = ex_imm;
      default:  alu_out = ex_a + ex_b; // B already holds the immediate for ADDI
    endcase
  end

  assign mem_addr = ex_a + ex_imm;
  assign link     = ex_pc + INSTR_BYTES;
  assign taken    = ex_is_branch && ((ex_a == ex_b) ^ ex_branch_ne);

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_valid <= 1'b0;
      redirect  <= 1'b0;
    end else begin
      mem_valid <= ex_valid;
      redirect  <= ex_valid && (ex_is_jal || taken);
    end
  end

  // Payload stays put until the next issue, so the memory stage can read it directly
  always_ff @(posedge clk) begin
    if (ex_valid) begin
      redirect_pc    <= ex_pc + ex_imm;
      mem_store_data <= ex_b;
      mem_rd         <= ex_rd;
      mem_wb_sel     <= ex_wb_sel;
      mem_is_load    <= ex_is_load;
      mem_is_store   <= ex_is_store;
      if (ex_is_load || ex_is_store) mem_result <= mem_addr;
      else if (ex_wb_sel == WB_LINK) mem_result <= link;
      else mem_result <= alu_out;
    end
  end

endmodule

`default_nettype wire

// ==== design/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode import core_pkg::*; (
  input  wire      clk,
  input  wire      reset,
  input  wire      fb_valid,
  input  instr_t   fb_instr,
  input  addr_t    fb_pc,
  output logic     fb_take,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  input  xlen_t    rs1_data,
  input  xlen_t    rs2_data,
  input  wire      retire,
  output logic     ex_valid,
  output alu_op_e  ex_alu_op,
  output wb_sel_e  ex_wb_sel,
  output reg_idx_t ex_rd,
  output xlen_t    ex_a,
  output xlen_t    ex_b,
  output xlen_t    ex_imm,
  output addr_t    ex_pc,
  output logic     ex_is_load,
  output logic     ex_is_store,
  output logic     ex_is_branch,
  output logic     ex_branch_ne,
  output logic     ex_is_jal
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  xlen_t      imm;
  alu_op_e    alu_op;
  wb_sel_e    wb_sel;
  logic       use_imm;  // ALU B operand is the immediate
  logic       is_load, is_store, is_branch, branch_ne, is_jal;
  logic       outstanding; // Back end holds an instruction

  assign opcode = fb_instr[6:0];
  assign funct3 = fb_instr[14:12];
  assign funct7 = fb_instr[31:25];
  assign rs1    = fb_instr[19:15];
  assign rs2    = fb_instr[24:20];

  assign imm_i = {{52{fb_instr[31]}}, fb_instr[31:20]};
  assign imm_s = {{52{fb_instr[31]}}, fb_instr[31:25], fb_instr[11:7]};
  assign imm_b = {{51{fb_instr[31]}}, fb_instr[31], fb_instr[7], fb_instr[30:25],
                  fb_instr[11:8], 1'b0};
  assign imm_u = {{32{fb_instr[31]}}, fb_instr[31:12], 12'b0};
  assign imm_j = {{43{fb_instr[31]}}, fb_instr[31], fb_instr[19:12], fb_instr[20],
                  fb_instr[30:21], 1'b0};

  always_comb begin
    alu_op    = ALU_ADD;
    wb_sel    = WB_NONE; // Unknown encodings retire as no-ops
    imm       = imm_i;
    use_imm   = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    is_jal    = 1'b0;
    case (opcode)
      OPC_OP_IMM: if (funct3 == 3'b000) begin // ADDI
        wb_sel  = WB_ALU;
        use_imm = 1'b1;
      end
      OPC_OP: begin
        wb_sel = WB_ALU;
        if ((funct3 == 3'b000) && (funct7 == 7'b0100000)) alu_op = ALU_SUB;
        else if (funct7 != 7'b0000000) wb_sel = WB_NONE;
        else if (funct3 == 3'b111) alu_op = ALU_AND;
        else if (funct3 == 3'b110) alu_op = ALU_OR;
        else if (funct3 == 3'b100) alu_op = ALU_XOR;
        else if (funct3 != 3'b000) wb_sel = WB_NONE;
      end
      OPC_LUI: begin
        alu_op = ALU_PASS;
        wb_sel = WB_ALU;
        imm    = imm_u;
      end
      OPC_LOAD: if (funct3 == FUNCT3_DOUBLE) begin
        wb_sel  = WB_LOAD;
        is_load = 1'b1;
      end
      OPC_STORE: if (funct3 == FUNCT3_DOUBLE) begin
        imm      = imm_s;
        is_store = 1'b1;
      end
      OPC_BRANCH: if (funct3[2:1] == 2'b00) begin // BEQ and BNE only
        imm       = imm_b;
        is_branch = 1'b1;
        branch_ne = funct3[0];
      end
      OPC_JAL: begin
        wb_sel = WB_LINK;
        imm    = imm_j;
        is_jal = 1'b1;
      end
      default: ;
    endcase
  end

  // Issue only into an empty back end, so no hazards exist
  assign fb_take = fb_valid && !outstanding;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 1'b0;
      ex_valid    <= 1'b0;
    end else begin
      ex_valid <= fb_take; // One cycle pulse
      if (fb_take) outstanding <= 1'b1;
      else if (retire) outstanding <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fb_take) begin
      ex_alu_op    <= alu_op;
      ex_wb_sel    <= wb_sel;
      ex_rd        <= fb_instr[11:7];
      ex_a         <= rs1_data;
      ex_b         <= use_imm ? imm : rs2_data;
      ex_imm       <= imm;
      ex_pc        <= fb_pc;
      ex_is_load   <= is_load;
      ex_is_store  <= is_store;
      ex_is_branch <= is_branch;
      ex_branch_ne <= branch_ne;
      ex_is_jal    <= is_jal;
    end
  end

endmodule

`default_nettype wire

// ==== design/instr_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_fetch import core_pkg::*; (
  input  wire   clk,
  input  wire   reset,
  input  addr_t entry,
  input  wire   redirect,
  input  addr_t redirect_pc,
  input  wire   fb_take,
  output logic  fb_valid,
  output instr_t fb_instr,
  output addr_t fb_pc,
  output logic  f_req,
  output addr_t f_addr,
  input  wire   f_ack,
  input  xlen_t f_rdata
);

  fetch_state_e state;
  addr_t        pc;
  addr_t        fetch_addr; // Held stable for the whole handshake
  logic         discard;    // Word in flight belongs to a flushed path
  logic         fetch_done; // Release phase ends this cycle
  instr_t       word;

  assign f_req      = (state == FETCH_REQ);
  assign f_addr     = fetch_addr;
  assign fetch_done = (state == FETCH_REL) && !f_ack;
  assign word       = fetch_addr[2] ? f_rdata[63:32] : f_rdata[31:0]; // Little endian halves

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= FETCH_IDLE;
      pc       <= entry;
      fb_valid <= 1'b0;
      discard  <= 1'b0;
    end else begin
      case (state)
        FETCH_IDLE: if (!fb_valid && !redirect) state <= FETCH_REQ; // Only into an empty buffer
        FETCH_REQ:  if (f_ack) state <= FETCH_REL;
        FETCH_REL: begin
          if (fetch_done) begin
            state   <= FETCH_IDLE;
            discard <= 1'b0;
            if (!discard && !redirect) begin
              fb_valid <= 1'b1;
              pc       <= fetch_addr + INSTR_BYTES;
            end
          end
        end
        default: state <= FETCH_IDLE;
      endcase
      if (fb_take) fb_valid <= 1'b0;
      // Flush wins over fill and take
      if (redirect) begin
        fb_valid <= 1'b0;
        pc       <= redirect_pc;
        if ((state == FETCH_REQ) || ((state == FETCH_REL) && f_ack)) discard <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state == FETCH_IDLE) && !fb_valid) fetch_addr <= pc;
    if ((state == FETCH_REQ) && f_ack) begin // rdata valid while ack is high
      fb_instr <= word;
      fb_pc    <= fetch_addr;
    end
  end

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import core_pkg::*; (
  input  wire   clk,
  input  wire   reset,
  input  wire   f_req,
  input  addr_t f_addr,
  output logic  f_ack,
  output xlen_t f_rdata,
  input  wire   d_req,
  input  wire   d_we,
  input  addr_t d_addr,
  input  xlen_t d_wdata,
  output logic  d_ack,
  output xlen_t d_rdata,
  output logic  mem_req,
  output logic  mem_we,
  output addr_t mem_addr,
  output xlen_t mem_wdata,
  input  wire   mem_ack,
  input  xlen_t mem_rdata
);

  arb_owner_e owner;

  always_ff @(posedge clk) begin
    if (reset) begin
      owner <= OWN_NONE;
    end else begin
      case (owner)
        OWN_NONE: begin
          if (d_req) owner <= OWN_DATA; // Data wins a tie
          else if (f_req) owner <= OWN_FETCH;
        end
        OWN_FETCH: if (!f_req && !mem_ack) owner <= OWN_NONE; // Handshake fully closed
        OWN_DATA:  if (!d_req && !mem_ack) owner <= OWN_NONE;
        default:   owner <= OWN_NONE;
      endcase
    end
  end

  assign mem_req   = ((owner == OWN_FETCH) && f_req) || ((owner == OWN_DATA) && d_req);
  assign mem_we    = (owner == OWN_DATA) && d_we;
  assign mem_addr  = (owner == OWN_DATA) ? d_addr : f_addr;
  assign mem_wdata = d_wdata;

  // Ack only to the owner
  assign f_ack   = (owner == OWN_FETCH) && mem_ack;
  assign d_ack   = (owner == OWN_DATA) && mem_ack;
  assign f_rdata = mem_rdata;
  assign d_rdata = mem_rdata;

endmodule

`default_nettype wire

// ==== design/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage import core_pkg::*; (
  input  wire      clk,
  input  wire      reset,
  input  wire      mem_valid,
  input  xlen_t    mem_result,
  input  xlen_t    mem_store_data,
  input  reg_idx_t mem_rd,
  input  wb_sel_e  mem_wb_sel,
  input  wire      mem_is_load,
  input  wire      mem_is_store,
  output logic     d_req,
  output logic     d_we,
  output addr_t    d_addr,
  output xlen_t    d_wdata,
  input  wire      d_ack,
  input  xlen_t    d_rdata,
  output logic     wb_en,
  output reg_idx_t wb_rd,
  output xlen_t    wb_data,
  output logic     retire
);

  mem_state_e state;
  xlen_t      load_data;

  assign d_req   = (state == MEM_REQ);
  assign d_we    = mem_is_store;
  assign d_addr  = mem_result;     // Effective address from execute
  assign d_wdata = mem_store_data;

  assign retire  = (state == MEM_RETIRE);
  assign wb_en   = retire && (mem_wb_sel != WB_NONE); // Stores, branches and no-ops skip
  assign wb_rd   = mem_rd;
  assign wb_data = (mem_wb_sel == WB_LOAD) ? load_data : mem_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= MEM_IDLE;
    end else begin
      case (state)
        MEM_IDLE: begin
          if (mem_valid) state <= (mem_is_load || mem_is_store) ? MEM_REQ : MEM_RETIRE;
        end
        MEM_REQ:    if (d_ack) state <= MEM_REL;
        MEM_REL:    if (!d_ack) state <= MEM_RETIRE; // Wait for the ack to fall
        MEM_RETIRE: state <= MEM_IDLE;
        default:    state <= MEM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == MEM_REQ) && d_ack) load_data <= d_rdata;
  end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_pkg::*; (
  input  wire      clk,
  input  wire      reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output xlen_t    rs1_data,
  output xlen_t    rs2_data,
  input  wire      wb_en,
  input  reg_idx_t wb_rd,
  input  xlen_t    wb_data
);

  xlen_t regs [32];

  // Combinational reads
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wb_en && (wb_rd != 5'd0)) begin // x0 is never written and stays zero
      regs[wb_rd] <= wb_data;
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/core_pkg.sv
design/reg_file.sv
design/instr_fetch.sv
design/instr_decode.sv
design/execute_unit.sv
design/mem_stage.sv
design/mem_arbiter.sv
design/core_top.sv
bench/mem_model.sv
bench/core_tb.sv
